/* include/id_settings.svh */
// widths, register count and nop encoding for the instruction decode stage
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// register and pc width
`define ID_XLEN     64

// fetched instruction word
`define ID_INST_WD  32

`define ID_GPR_NUM  32 // x0..x31

// addi x0, x0, 0 which replaces a wrong-path fetch
`define ID_NOP_INST 32'h0000_0013

`endif

/* design/id_pkg.sv */
// types shared by the decode stage blocks: words, indices, opcodes, instruction views
`include "id_settings.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]            xlen_t;
  typedef logic [$clog2(`ID_GPR_NUM)-1:0] gpr_addr_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [2:0] {
    BEQ = 3'b000,
    BNE = 3'b001,
    BLT = 3'b100,
    BGE = 3'b101
  } br_func_e; // as found in funct3

  typedef enum logic [1:0] {
    ADD = 2'b00,
    SUB = 2'b01
  } alu_op_e;

  // r and i formats, imm[11:0] sits in funct7 and rs2
  typedef struct packed {
    logic [6:0] funct7;
    gpr_addr_t  rs2;
    gpr_addr_t  rs1;
    logic [2:0] funct3;
    gpr_addr_t  rd;
    opcode_e    opcode;
  } inst_i_t;

  // s and b formats, immediate split around the register fields
  typedef struct packed {
    logic [6:0] imm_hi;
    gpr_addr_t  rs2;
    gpr_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } inst_sb_t;

  typedef union packed {
    inst_i_t  ir;
    inst_sb_t sb;
  } inst_u;

endpackage

/* design/id_input_latch.sv */
// decode stage input register: valid bit plus instruction and pc from fetch
`timescale 1ns/1ps
`include "id_settings.svh"

module id_input_latch (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_capture,  // stage allowin
  input  logic                   i_redirect,
  input  logic                   i_fs_valid,
  input  logic [`ID_INST_WD-1:0] i_fs_inst,
  input  id_pkg::xlen_t          i_fs_pc,
  output logic                   o_ds_valid,
  output logic [`ID_INST_WD-1:0] o_inst,
  output id_pkg::xlen_t          o_pc
);

  // valid follows fetch whenever the stage can take a new item
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ds_valid <= 1'b0;
    end else if (i_capture) begin
      o_ds_valid <= i_fs_valid;
    end
  end

  // wrong-path word turns into a nop, pc kept
  always_ff @(posedge i_clk) begin
    if (i_capture && i_fs_valid) begin
      o_inst <= i_redirect ? `ID_NOP_INST : i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

/* design/id_decoder.sv */
// decoder for the reduced rv64 integer subset: fields, immediate and control flags
`timescale 1ns/1ps
`include "id_settings.svh"

module id_decoder (
  input  id_pkg::inst_u     i_inst,
  output id_pkg::gpr_addr_t o_rs1,
  output id_pkg::gpr_addr_t o_rs2,
  output id_pkg::gpr_addr_t o_rd,
  output logic              o_uses_rs1,
  output logic              o_uses_rs2,
  output id_pkg::xlen_t     o_imm,
  output id_pkg::alu_op_e   o_alu_op,
  output logic              o_src2_imm,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output logic              o_load_sel,
  output logic              o_bren,
  output id_pkg::br_func_e  o_brfunc,
  output logic              o_jal,
  output logic              o_jalr,
  output logic              o_invalid
);
  import id_pkg::*;

  inst_i_t                ir;
  inst_sb_t               sb;
  logic [`ID_INST_WD-1:0] raw;
  xlen_t                  imm_i;
  xlen_t                  imm_s;
  xlen_t                  imm_b;
  xlen_t                  imm_j;
  logic                   wr_rd; // writes rd before the x0 check

  assign ir  = i_inst.ir;
  assign sb  = i_inst.sb;
  assign raw = i_inst;

  assign imm_i = {{(`ID_XLEN-12){ir.funct7[6]}}, ir.funct7, ir.rs2};
  assign imm_s = {{(`ID_XLEN-12){sb.imm_hi[6]}}, sb.imm_hi, sb.imm_lo};
  assign imm_b = {{(`ID_XLEN-13){sb.imm_hi[6]}}, sb.imm_hi[6], sb.imm_lo[0],
                  sb.imm_hi[5:0], sb.imm_lo[4:1], 1'b0};
  // j format is scrambled across the upper bits
  assign imm_j = {{(`ID_XLEN-21){raw[31]}}, raw[31], raw[19:12], raw[20],
                  raw[30:21], 1'b0};

  assign o_rs1     = ir.rs1;
  assign o_rs2     = ir.rs2;
  assign o_rd      = ir.rd;
  assign o_brfunc  = br_func_e'(ir.funct3);
  assign o_gpr_wen = wr_rd && (ir.rd != '0);

  always_comb begin
    o_uses_rs1 = 1'b0;
    o_uses_rs2 = 1'b0;
    o_imm      = '0;
    o_alu_op   = ADD;
    o_src2_imm = 1'b0;
    wr_rd      = 1'b0;
    o_mem_ren  = 1'b0;
    o_mem_wen  = 1'b0;
    o_load_sel = 1'b0;
    o_bren     = 1'b0;
    o_jal      = 1'b0;
    o_jalr     = 1'b0;
    o_invalid  = 1'b0;
    case (ir.opcode)
      OP_IMM: begin
        o_invalid  = (ir.funct3 != 3'b000); // addi only
        o_uses_rs1 = 1'b1;
        o_imm      = imm_i;
        o_src2_imm = 1'b1;
        wr_rd      = !o_invalid;
      end
      OP: begin
        o_uses_rs1 = 1'b1;
        o_uses_rs2 = 1'b1;
        if (ir.funct3 == 3'b000 && ir.funct7 == 7'b0000000) begin
          wr_rd = 1'b1;
        end else if (ir.funct3 == 3'b000 && ir.funct7 == 7'b0100000) begin
          o_alu_op = SUB;
          wr_rd    = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      LOAD: begin
        o_invalid  = (ir.funct3 != 3'b011); // ld only
        o_uses_rs1 = 1'b1;
        o_imm      = imm_i;
        o_src2_imm = 1'b1;
        o_mem_ren  = !o_invalid;
        o_load_sel = !o_invalid;
        wr_rd      = !o_invalid;
      end
      STORE: begin
        o_invalid  = (ir.funct3 != 3'b011); // sd only
        o_uses_rs1 = 1'b1;
        o_uses_rs2 = 1'b1;
        o_imm      = imm_s;
        o_src2_imm = 1'b1;
        o_mem_wen  = !o_invalid;
      end
      BRANCH: begin
        o_uses_rs1 = 1'b1;
        o_uses_rs2 = 1'b1;
        o_imm      = imm_b;
        case (br_func_e'(ir.funct3))
          BEQ, BNE, BLT, BGE: o_bren = 1'b1;
          default:            o_invalid = 1'b1;
        endcase
      end
      JAL: begin
        o_imm = imm_j;
        o_jal = 1'b1;
        wr_rd = 1'b1;
      end
      JALR: begin
        o_invalid  = (ir.funct3 != 3'b000);
        o_uses_rs1 = 1'b1;
        o_imm      = imm_i;
        o_jalr     = !o_invalid;
        wr_rd      = !o_invalid;
      end
      default: o_invalid = 1'b1;
    endcase
  end

endmodule

/* design/id_gpr_file.sv */
// general register file: 32 x 64, two async reads, one clocked write, x0 fixed at zero
`timescale 1ns/1ps
`include "id_settings.svh"

module id_gpr_file (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  id_pkg::gpr_addr_t i_raddr1,
  input  id_pkg::gpr_addr_t i_raddr2,
  input  logic              i_wen,
  input  id_pkg::gpr_addr_t i_waddr,
  input  id_pkg::xlen_t     i_wdata,
  output id_pkg::xlen_t     o_rdata1,
  output id_pkg::xlen_t     o_rdata2
);
  import id_pkg::*;

  xlen_t regs [`ID_GPR_NUM];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `ID_GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin // x0 writes dropped
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* design/id_operand_bypass.sv */
// operand forwarding from ex, mem and wb plus load-use hazard detection
`timescale 1ns/1ps

module id_operand_bypass (
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  logic              i_uses_rs1,
  input  logic              i_uses_rs2,
  input  id_pkg::xlen_t     i_rf_rdata1,
  input  id_pkg::xlen_t     i_rf_rdata2,
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::xlen_t     i_es_result,
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::xlen_t     i_ms_result,
  input  id_pkg::gpr_addr_t i_ws_rd,
  input  id_pkg::xlen_t     i_ws_result,
  input  logic              i_es_load_sel,
  output id_pkg::xlen_t     o_rs1_data,
  output id_pkg::xlen_t     o_rs2_data,
  output logic              o_load_stall
);
  import id_pkg::*;

  // youngest producer wins, rd of zero never forwards
  function automatic xlen_t pick(input gpr_addr_t rs, input xlen_t rf_data);
    xlen_t data;
    if (i_es_rd != '0 && rs == i_es_rd) begin
      data = i_es_result;
    end else if (i_ms_rd != '0 && rs == i_ms_rd) begin
      data = i_ms_result;
    end else if (i_ws_rd != '0 && rs == i_ws_rd) begin
      data = i_ws_result;
    end else begin
      data = rf_data;
    end
    return data;
  endfunction

  always_comb begin
    o_rs1_data = pick(i_rs1, i_rf_rdata1);
    o_rs2_data = pick(i_rs2, i_rf_rdata2);
  end

  // load result only exists once it reaches mem
  assign o_load_stall = i_es_load_sel &&
                        ((i_uses_rs1 && (i_es_rd == i_rs1)) ||
                         (i_uses_rs2 && (i_es_rd == i_rs2)));

endmodule

/* design/id_branch_unit.sv */
// branch condition and jump target evaluation, with redirect check against fetch pc
`timescale 1ns/1ps
`include "id_settings.svh"

module id_branch_unit (
  input  id_pkg::xlen_t    i_pc,
  input  id_pkg::xlen_t    i_imm,
  input  id_pkg::xlen_t    i_rs1_data,
  input  id_pkg::xlen_t    i_rs2_data,
  input  logic             i_bren,
  input  id_pkg::br_func_e i_brfunc,
  input  logic             i_jal,
  input  logic             i_jalr,
  input  id_pkg::xlen_t    i_fs_pc,
  output logic             o_br_sel,
  output id_pkg::xlen_t    o_br_target,
  output logic             o_br_differs
);
  import id_pkg::*;

  logic  eq;
  logic  lt;
  logic  cond;
  xlen_t jalr_sum;

  assign eq = (i_rs1_data == i_rs2_data);
  assign lt = ($signed(i_rs1_data) < $signed(i_rs2_data));

  always_comb begin
    case (i_brfunc)
      BEQ:     cond = eq;
      BNE:     cond = !eq;
      BLT:     cond = lt;
      BGE:     cond = !lt;
      default: cond = 1'b0;
    endcase
  end

  assign o_br_sel = (i_bren && cond) || i_jal || i_jalr;

  assign jalr_sum    = i_rs1_data + i_imm;
  assign o_br_target = i_jalr ? {jalr_sum[`ID_XLEN-1:1], 1'b0} // lsb cleared
                              : i_pc + i_imm;

  // fetch already on the right path means no redirect
  assign o_br_differs = (o_br_target != i_fs_pc);

endmodule

/* design/id_stage.sv */
// instruction decode stage: input register, decode, register file, forwarding, branch resolve
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_fs_to_ds_valid,
  input  logic [`ID_INST_WD-1:0] i_fs_inst,
  input  id_pkg::xlen_t          i_fs_pc,
  output logic                   o_ds_allowin,
  input  logic                   i_es_allowin,
  output logic                   o_ds_to_es_valid,
  output id_pkg::xlen_t          o_ds_pc,
  output id_pkg::xlen_t          o_rs1_data,
  output id_pkg::xlen_t          o_rs2_data,
  output id_pkg::xlen_t          o_imm,
  output id_pkg::gpr_addr_t      o_rd,
  output id_pkg::alu_op_e        o_alu_op,
  output logic                   o_src2_imm,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output logic                   o_load_sel,
  output logic                   o_invalid_inst,
  output logic                   o_br_taken,
  output id_pkg::xlen_t          o_br_target,
  input  logic                   i_ws_wen,
  input  id_pkg::gpr_addr_t      i_ws_waddr,
  input  id_pkg::xlen_t          i_ws_wdata,
  input  id_pkg::gpr_addr_t      i_es_rd,
  input  id_pkg::xlen_t          i_es_result,
  input  id_pkg::gpr_addr_t      i_ms_rd,
  input  id_pkg::xlen_t          i_ms_result,
  input  id_pkg::gpr_addr_t      i_ws_rd,
  input  id_pkg::xlen_t          i_ws_result,
  input  logic                   i_es_load_sel
);
  import id_pkg::*;

  logic                   ds_valid;
  logic                   ds_ready_go;
  logic                   load_stall;
  logic [`ID_INST_WD-1:0] ds_inst;
  gpr_addr_t              rs1;
  gpr_addr_t              rs2;
  logic                   uses_rs1;
  logic                   uses_rs2;
  xlen_t                  rf_rdata1;
  xlen_t                  rf_rdata2;
  logic                   bren;
  br_func_e               brfunc;
  logic                   jal;
  logic                   jalr;
  logic                   br_sel;
  logic                   br_differs;

  assign ds_ready_go      = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  // redirect only from a live, unstalled instruction
  assign o_br_taken       = ds_valid && ds_ready_go && br_sel && br_differs;

  id_input_latch u_latch (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_capture  (o_ds_allowin),
    .i_redirect (o_br_taken),
    .i_fs_valid (i_fs_to_ds_valid),
    .i_fs_inst  (i_fs_inst),
    .i_fs_pc    (i_fs_pc),
    .o_ds_valid (ds_valid),
    .o_inst     (ds_inst),
    .o_pc       (o_ds_pc)
  );

  id_decoder u_decoder (
    .i_inst     (ds_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (o_rd),
    .o_uses_rs1 (uses_rs1),
    .o_uses_rs2 (uses_rs2),
    .o_imm      (o_imm),
    .o_alu_op   (o_alu_op),
    .o_src2_imm (o_src2_imm),
    .o_gpr_wen  (o_gpr_wen),
    .o_mem_ren  (o_mem_ren),
    .o_mem_wen  (o_mem_wen),
    .o_load_sel (o_load_sel),
    .o_bren     (bren),
    .o_brfunc   (brfunc),
    .o_jal      (jal),
    .o_jalr     (jalr),
    .o_invalid  (o_invalid_inst)
  );

  id_gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_ws_wen),
    .i_waddr  (i_ws_waddr),
    .i_wdata  (i_ws_wdata),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_operand_bypass u_bypass (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_uses_rs1    (uses_rs1),
    .i_uses_rs2    (uses_rs2),
    .i_rf_rdata1   (rf_rdata1),
    .i_rf_rdata2   (rf_rdata2),
    .i_es_rd       (i_es_rd),
    .i_es_result   (i_es_result),
    .i_ms_rd       (i_ms_rd),
    .i_ms_result   (i_ms_result),
    .i_ws_rd       (i_ws_rd),
    .i_ws_result   (i_ws_result),
    .i_es_load_sel (i_es_load_sel),
    .o_rs1_data    (o_rs1_data),
    .o_rs2_data    (o_rs2_data),
    .o_load_stall  (load_stall)
  );

  id_branch_unit u_bru (
    .i_pc         (o_ds_pc),
    .i_imm        (o_imm),
    .i_rs1_data   (o_rs1_data), // forwarded values
    .i_rs2_data   (o_rs2_data),
    .i_bren       (bren),
    .i_brfunc     (brfunc),
    .i_jal        (jal),
    .i_jalr       (jalr),
    .i_fs_pc      (i_fs_pc),
    .o_br_sel     (br_sel),
    .o_br_target  (o_br_target),
    .o_br_differs (br_differs)
  );

endmodule

/* testbench/id_checker.sv */
// decode stage checker: compares the issue and redirect ports with expected values
`timescale 1ns/1ps

module id_checker (
  input  logic        i_clk,
  input  logic [1:0]  i_mode,  // 1 stall, 2 hold, 3 just out of reset
  input  logic [63:0] i_pc,
  input  logic [4:0]  i_rd,
  input  logic [63:0] i_imm,
  input  logic [6:0]  i_ctl,
  input  logic [63:0] i_rs1,
  input  logic [63:0] i_rs2,
  input  logic        i_chk1,
  input  logic        i_chk2,
  input  logic        i_taken,
  input  logic [63:0] i_target,
  output int          o_errors,
  output int          o_issues
);

  int errors = 0;
  int issues = 0;

  assign o_errors = errors;
  assign o_issues = issues;

  task automatic cmp(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // sampled on the rising edge, before the stage updates
  always @(posedge i_clk) begin
    case (i_mode)
      2'd1, 2'd2: begin
        cmp("valid", 64'(tb_id_stage.u_dut.o_ds_to_es_valid), 64'(i_mode == 2'd2));
        cmp("allowin", 64'(tb_id_stage.u_dut.o_ds_allowin), 64'd0);
      end
      2'd3: begin
        cmp("valid", 64'(tb_id_stage.u_dut.o_ds_to_es_valid), 64'd0);
        cmp("br_taken", 64'(tb_id_stage.u_dut.o_br_taken), 64'd0);
        cmp("allowin", 64'(tb_id_stage.u_dut.o_ds_allowin), 64'd1);
      end
      default: ;
    endcase
    if (tb_id_stage.u_dut.o_ds_to_es_valid && tb_id_stage.u_dut.i_es_allowin) begin
      issues++;
      cmp("pc", tb_id_stage.u_dut.o_ds_pc, i_pc);
      cmp("rd", 64'(tb_id_stage.u_dut.o_rd), 64'(i_rd));
      cmp("imm", tb_id_stage.u_dut.o_imm, i_imm);
      cmp("alu_op", 64'(tb_id_stage.u_dut.o_alu_op), 64'(i_ctl[6]));
      cmp("src2_imm", 64'(tb_id_stage.u_dut.o_src2_imm), 64'(i_ctl[5]));
      cmp("gpr_wen", 64'(tb_id_stage.u_dut.o_gpr_wen), 64'(i_ctl[4]));
      cmp("mem_ren", 64'(tb_id_stage.u_dut.o_mem_ren), 64'(i_ctl[3]));
      cmp("mem_wen", 64'(tb_id_stage.u_dut.o_mem_wen), 64'(i_ctl[2]));
      cmp("load_sel", 64'(tb_id_stage.u_dut.o_load_sel), 64'(i_ctl[1]));
      cmp("invalid_inst", 64'(tb_id_stage.u_dut.o_invalid_inst), 64'(i_ctl[0]));
      if (i_chk1) begin
        cmp("rs1_data", tb_id_stage.u_dut.o_rs1_data, i_rs1);
      end
      if (i_chk2) begin
        cmp("rs2_data", tb_id_stage.u_dut.o_rs2_data, i_rs2);
      end
      cmp("br_taken", 64'(tb_id_stage.u_dut.o_br_taken), 64'(i_taken));
      if (i_taken) begin
        cmp("br_target", tb_id_stage.u_dut.o_br_target, i_target);
      end
    end
  end

endmodule

/* testbench/id_properties.sv */
// handshake assertions for the decode stage, bound into id_stage
`timescale 1ns/1ps

module id_properties (
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_fs_to_ds_valid,
  input logic              i_es_allowin,
  input logic              i_es_load_sel,
  input logic              o_ds_to_es_valid,
  input logic              o_ds_allowin,
  input logic              o_br_taken,
  input logic              o_gpr_wen,
  input id_pkg::xlen_t     o_ds_pc,
  input id_pkg::xlen_t     o_imm,
  input id_pkg::gpr_addr_t o_rd
);

  // without a load in execute, nothing can stall the held item
  idle_stage_open: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!o_ds_to_es_valid && !i_es_load_sel) |-> o_ds_allowin)
    else $error("stage not open for a new item while it has nothing to issue");

  redirect_leaves_nop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_br_taken && o_ds_allowin && i_fs_to_ds_valid) |=> (o_rd == '0 && !o_gpr_wen))
    else $error("wrong-path word behind a redirect was not turned into a nop");

  // held item must not move under back-pressure
  hold_is_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=> ($stable(o_ds_pc) && $stable(o_imm) && $stable(o_rd)))
    else $error("issue fields changed while execute held the stage");

endmodule

bind id_stage id_properties u_props (.*);

/* testbench/tb_id_stage.sv */
// testbench for the decode stage: instruction table with expected issue fields, run in a loop
`timescale 1ns/1ps

module tb_id_stage;

  typedef struct packed {
    logic [31:0] inst;
    logic [63:0] pc;
    logic [63:0] fpc;   // fetch pc while the row is held
    logic [4:0]  es;
    logic [4:0]  ms;
    logic [4:0]  ws;
    logic [1:0]  fix;   // preset es/ms results, 0 random
    logic [1:0]  mode;  // 1 load-use stall, 2 execute back-pressure
    logic [2:0]  opt;   // {no fetch, fetch behind, write-back}
    logic [4:0]  waddr;
    logic [4:0]  rd;
    logic [63:0] imm;
    logic [6:0]  ctl;   // sub src2_imm gpr_wen mem_ren mem_wen load invalid
    logic [2:0]  s1;    // 0 unchecked, 1 zero, 2 rf, 3 es, 4 ms, 5 ws
    logic [2:0]  s2;
    logic        tk;
    logic [63:0] tgt;
  } row_t;

  localparam int NROWS = 21;
  localparam int WD_NS = (NROWS * 10 + 16 + 20) * 20;

  logic            i_clk;
  logic            i_rst_n;
  logic            i_fs_to_ds_valid;
  logic [31:0]     i_fs_inst;
  logic [63:0]     i_fs_pc;
  logic            i_es_allowin;
  logic            i_ws_wen;
  logic [4:0]      i_ws_waddr;
  logic [63:0]     i_ws_wdata;
  logic [4:0]      i_es_rd;
  logic [63:0]     i_es_result;
  logic [4:0]      i_ms_rd;
  logic [63:0]     i_ms_result;
  logic [4:0]      i_ws_rd;
  logic [63:0]     i_ws_result;
  logic            i_es_load_sel;
  logic            o_ds_allowin;
  logic            o_ds_to_es_valid;
  logic [63:0]     o_ds_pc;
  logic [63:0]     o_rs1_data;
  logic [63:0]     o_rs2_data;
  logic [63:0]     o_imm;
  logic [4:0]      o_rd;
  id_pkg::alu_op_e o_alu_op;
  logic            o_src2_imm;
  logic            o_gpr_wen;
  logic            o_mem_ren;
  logic            o_mem_wen;
  logic            o_load_sel;
  logic            o_invalid_inst;
  logic            o_br_taken;
  logic [63:0]     o_br_target;

  logic [1:0]  exp_mode;
  logic [63:0] exp_pc;
  logic [4:0]  exp_rd;
  logic [63:0] exp_imm;
  logic [6:0]  exp_ctl;
  logic [63:0] exp_rs1;
  logic [63:0] exp_rs2;
  logic        exp_chk1;
  logic        exp_chk2;
  logic        exp_tk;
  logic [63:0] exp_tgt;
  int          errors;
  int          issues;
  row_t        rows [NROWS];
  logic [63:0] shadow [32]; // expected register file contents

  id_stage u_dut (.*);

  id_checker u_chk (
    .i_clk    (i_clk),
    .i_mode   (exp_mode),
    .i_pc     (exp_pc),
    .i_rd     (exp_rd),
    .i_imm    (exp_imm),
    .i_ctl    (exp_ctl),
    .i_rs1    (exp_rs1),
    .i_rs2    (exp_rs2),
    .i_chk1   (exp_chk1),
    .i_chk2   (exp_chk2),
    .i_taken  (exp_tk),
    .i_target (exp_tgt),
    .o_errors (errors),
    .o_issues (issues)
  );

  always #10 i_clk = ~i_clk;

  function automatic logic [63:0] src_value(input logic [2:0] code, input logic [4:0] idx);
    logic [63:0] v;
    case (code)
      3'd2:    v = shadow[idx];
      3'd3:    v = i_es_result;
      3'd4:    v = i_ms_result;
      3'd5:    v = i_ws_result;
      default: v = 64'd0;
    endcase
    return v;
  endfunction

  task automatic fill_table();
    rows[0]  = '{32'hFFB00093, 64'h00, 64'h04, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b000, 5'd0,
                 5'd1, -64'd5, 7'b0110000, 3'd1, 3'd0, 1'b0, 64'h0};
    rows[1]  = '{32'h00500013, 64'h04, 64'h08, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b001, 5'd7,
                 5'd0, 64'd5, 7'b0100000, 3'd1, 3'd0, 1'b0, 64'h0};
    rows[2]  = '{32'h000381B3, 64'h08, 64'h0c, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b001, 5'd0,
                 5'd3, 64'd0, 7'b0010000, 3'd2, 3'd1, 1'b0, 64'h0};
    rows[3]  = '{32'h40208233, 64'h0c, 64'h10, 5'd1, 5'd1, 5'd2, 2'd0, 2'd0, 3'b000, 5'd0,
                 5'd4, 64'd0, 7'b1010000, 3'd3, 3'd5, 1'b0, 64'h0};
    rows[4]  = '{32'h002082B3, 64'h10, 64'h14, 5'd3, 5'd1, 5'd1, 2'd0, 2'd0, 3'b000, 5'd0,
                 5'd5, 64'd0, 7'b0010000, 3'd4, 3'd2, 1'b0, 64'h0};
    rows[5]  = '{32'h01043303, 64'h14, 64'h18, 5'd0, 5'd0, 5'd8, 2'd0, 2'd0, 3'b000, 5'd0,
                 5'd6, 64'd16, 7'b0111010, 3'd5, 3'd0, 1'b0, 64'h0};
    rows[6]  = '{32'hFE953C23, 64'h18, 64'h1c, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b000, 5'd0,
                 5'd24, -64'd8, 7'b0100100, 3'd2, 3'd2, 1'b0, 64'h0};
    rows[7]  = '{32'h0000007F, 64'h1c, 64'h20, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b000, 5'd0,
                 5'd0, 64'd0, 7'b0000001, 3'd0, 3'd0, 1'b0, 64'h0};
    rows[8]  = '{32'h00D605B3, 64'h20, 64'h24, 5'd12, 5'd0, 5'd0, 2'd0, 2'd1, 3'b000, 5'd0,
                 5'd11, 64'd0, 7'b0010000, 3'd3, 3'd2, 1'b0, 64'h0};
    rows[9]  = '{32'h00170713, 64'h24, 64'h28, 5'd0, 5'd0, 5'd0, 2'd0, 2'd2, 3'b000, 5'd0,
                 5'd14, 64'd1, 7'b0110000, 3'd2, 3'd0, 1'b0, 64'h0};
    // branches and jumps, a redirect leaves a nop row behind it
    rows[10] = '{32'h00208863, 64'h100, 64'h104, 5'd1, 5'd2, 5'd0, 2'd1, 2'd0, 3'b010, 5'd0,
                 5'd16, 64'd16, 7'b0000000, 3'd3, 3'd4, 1'b1, 64'h110};
    rows[11] = '{32'h0, 64'h104, 64'h104, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b100, 5'd0,
                 5'd0, 64'd0, 7'b0100000, 3'd1, 3'd0, 1'b0, 64'h0};
    rows[12] = '{32'h00209863, 64'h200, 64'h204, 5'd1, 5'd2, 5'd0, 2'd1, 2'd0, 3'b000, 5'd0,
                 5'd16, 64'd16, 7'b0000000, 3'd3, 3'd4, 1'b0, 64'h0};
    rows[13] = '{32'h0020C863, 64'h300, 64'h304, 5'd1, 5'd2, 5'd0, 2'd2, 2'd0, 3'b010, 5'd0,
                 5'd16, 64'd16, 7'b0000000, 3'd3, 3'd4, 1'b1, 64'h310};
    rows[14] = '{32'h0, 64'h304, 64'h304, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b100, 5'd0,
                 5'd0, 64'd0, 7'b0100000, 3'd1, 3'd0, 1'b0, 64'h0};
    rows[15] = '{32'h0020D863, 64'h400, 64'h404, 5'd1, 5'd2, 5'd0, 2'd2, 2'd0, 3'b000, 5'd0,
                 5'd16, 64'd16, 7'b0000000, 3'd3, 3'd4, 1'b0, 64'h0};
    rows[16] = '{32'h008000EF, 64'h500, 64'h508, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b000, 5'd0,
                 5'd1, 64'd8, 7'b0010000, 3'd0, 3'd0, 1'b0, 64'h0};
    rows[17] = '{32'h008000EF, 64'h600, 64'h604, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b010, 5'd0,
                 5'd1, 64'd8, 7'b0010000, 3'd0, 3'd0, 1'b1, 64'h608};
    rows[18] = '{32'h0, 64'h604, 64'h604, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b100, 5'd0,
                 5'd0, 64'd0, 7'b0100000, 3'd1, 3'd0, 1'b0, 64'h0};
    rows[19] = '{32'h004082E7, 64'h700, 64'h704, 5'd1, 5'd0, 5'd0, 2'd3, 2'd0, 3'b010, 5'd0,
                 5'd5, 64'd4, 7'b0010000, 3'd3, 3'd0, 1'b1, 64'h1004};
    rows[20] = '{32'h0, 64'h704, 64'h704, 5'd0, 5'd0, 5'd0, 2'd0, 2'd0, 3'b100, 5'd0,
                 5'd0, 64'd0, 7'b0100000, 3'd1, 3'd0, 1'b0, 64'h0};
  endtask

  // entered and left on a falling edge
  task automatic apply_row(input row_t r);
    i_es_rd     = r.es;
    i_ms_rd     = r.ms;
    i_ws_rd     = r.ws;
    i_es_result = {$urandom, $urandom};
    i_ms_result = {$urandom, $urandom};
    i_ws_result = {$urandom, $urandom};
    case (r.fix)
      2'd1: begin
        i_es_result = 64'h1234;
        i_ms_result = 64'h1234;
      end
      2'd2: begin
        i_es_result = -64'd1;
        i_ms_result = 64'd1;
      end
      2'd3: i_es_result = 64'h1001;
      default: ;
    endcase
    i_es_load_sel = (r.mode == 2'd1);
    i_es_allowin  = (r.mode != 2'd2);
    i_ws_wen      = r.opt[0];
    i_ws_waddr    = r.waddr;
    i_ws_wdata    = {$urandom, $urandom};
    if (r.opt[0] && r.waddr != 5'd0) begin
      shadow[r.waddr] = i_ws_wdata;
    end
    exp_pc   = r.pc;
    exp_rd   = r.rd;
    exp_imm  = r.imm;
    exp_ctl  = r.ctl;
    exp_rs1  = src_value(r.s1, r.inst[19:15]);
    exp_rs2  = src_value(r.s2, r.inst[24:20]);
    exp_chk1 = (r.s1 != 3'd0);
    exp_chk2 = (r.s2 != 3'd0);
    exp_tk   = r.tk;
    exp_tgt  = r.tgt;
    if (!r.opt[2]) begin
      i_fs_to_ds_valid = 1'b1;
      i_fs_inst        = r.inst;
      i_fs_pc          = r.pc;
      @(negedge i_clk);
    end
    i_fs_to_ds_valid = r.opt[1];
    i_fs_inst        = 32'h0010_0093; // wrong-path word behind a branch
    i_fs_pc          = r.fpc;
    i_ws_wen         = 1'b0;
    if (r.mode != 2'd0) begin
      exp_mode = r.mode;
      repeat (3) @(negedge i_clk);
      exp_mode      = 2'd0;
      i_es_load_sel = 1'b0;
      i_es_allowin  = 1'b1;
    end
    do @(posedge i_clk); while (!(o_ds_to_es_valid && i_es_allowin));
    @(negedge i_clk);
    i_fs_to_ds_valid = 1'b0;
  endtask

  initial begin
    i_clk            = 1'b0;
    i_rst_n          = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = '0;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_ws_wen         = 1'b0;
    i_ws_waddr       = '0;
    i_ws_wdata       = '0;
    i_es_rd          = '0;
    i_es_result      = '0;
    i_ms_rd          = '0;
    i_ms_result      = '0;
    i_ws_rd          = '0;
    i_ws_result      = '0;
    i_es_load_sel    = 1'b0;
    exp_mode         = 2'd0;
    exp_pc           = '0;
    exp_rd           = '0;
    exp_imm          = '0;
    exp_ctl          = '0;
    exp_rs1          = '0;
    exp_rs2          = '0;
    exp_chk1         = 1'b0;
    exp_chk2         = 1'b0;
    exp_tk           = 1'b0;
    exp_tgt          = '0;
    void'($urandom(32'hd3fa));
    for (int i = 0; i < 32; i++) begin
      shadow[i] = 64'd0;
    end
    fill_table();
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n  = 1'b1;
    exp_mode = 2'd3; // idle state check on the first edge out of reset
    @(negedge i_clk);
    exp_mode = 2'd0;
    for (int n = 0; n < NROWS; n++) begin
      apply_row(rows[n]);
    end
    @(negedge i_clk);
    $display("errors: %0d, issues seen: %0d of %0d", errors, issues, NROWS);
    if (errors == 0 && issues == NROWS) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WD_NS);
    $display("the run timed out after %0d ns without finishing the table", WD_NS);
    $display("test failed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
design/id_pkg.sv
design/id_input_latch.sv
design/id_decoder.sv
design/id_gpr_file.sv
design/id_operand_bypass.sv
design/id_branch_unit.sv
design/id_stage.sv
testbench/id_checker.sv
testbench/id_properties.sv
testbench/tb_id_stage.sv

/* Makefile */
SIM   := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_id_stage
FLIST := flist.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fails unless the run passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
